/* board/board_store.sv */
`default_nettype none

module board_store import tetris_pkg::*; #(
	parameter int FIELD_COLS = tetris_pkg::FIELD_COLS,
	parameter int FIELD_ROWS = tetris_pkg::FIELD_ROWS
) (
	input logic ADDR,
	input logic rst_n,
	input logic start_over,
	input col_t cell_col [4],
	input row_t cell_row [4],
	output logic [FIELD_COLS*FIELD_ROWS-1:0] occupied,
	output logic stop,
	output logic hit,
	output logic clear,
	output logic [15:0] score
);

	localparam int CW = $clog2(FIELD_COLS);
	localparam int RW = $clog2(FIELD_ROWS);

	// row 0 at the top
	logic [FIELD_ROWS-1:0][FIELD_COLS-1:0] board;
	logic [FIELD_ROWS-1:0][FIELD_COLS-1:0] shifted;
	logic land;
	logic touch;
	logic full_found;
	logic [RW-1:0] full_row;

	assign occupied = board;
	assign shifted = {board[FIELD_ROWS-2:0], {FIELD_COLS{1'b0}}};

	function automatic logic in_field(input int c, input int r);
		return (c >= 0) && (c < FIELD_COLS) && (r >= 0) && (r < FIELD_ROWS);
	endfunction

	function automatic logic occ_at(input int c, input int r);
		if (!in_field(c, r))
			return 1'b0;
		return board[RW'(r)][CW'(c)];
	endfunction

	// own cells may already sit in the board right after a lock
	function automatic logic is_piece(input int c, input int r);
		logic found;
		found = 1'b0;
		for (int j = 0; j < 4; j++)
			if (int'(cell_col[j]) == c && int'(cell_row[j]) == r)
				found = 1'b1;
		return found;
	endfunction

	function automatic logic blocked(input int c, input int r);
		return occ_at(c, r) && !is_piece(c, r);
	endfunction

	always_comb begin
		int c;
		int r;
		land = 1'b0;
		touch = 1'b0;
		for (int i = 0; i < 4; i++) begin
			c = int'(cell_col[i]);
			r = int'(cell_row[i]);
			if (r + 1 >= FIELD_ROWS || blocked(c, r + 1))
				land = 1'b1;
			if (c - 1 < 0 || c + 1 >= FIELD_COLS)
				touch = 1'b1;  // field edge
			else if (blocked(c - 1, r) || blocked(c + 1, r))
				touch = 1'b1;
		end
	end

	// last match wins, so the lowest full row
	always_comb begin
		full_found = 1'b0;
		full_row = '0;
		for (int r = 0; r < FIELD_ROWS; r++) begin
			if (&board[r]) begin
				full_found = 1'b1;
				full_row = RW'(r);
			end
		end
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			board <= '0;
			score <= '0;
			stop <= 1'b0;
			hit <= 1'b0;
			clear <= 1'b0;
		end else begin
			stop <= land;
			hit <= touch;
			clear <= 1'b0;
			if (start_over) begin
				board <= '0;
				score <= '0;
			end else if (land) begin
				for (int i = 0; i < 4; i++)
					if (in_field(int'(cell_col[i]), int'(cell_row[i])))
						board[RW'(cell_row[i])][CW'(cell_col[i])] <= 1'b1;
			end else if (full_found) begin
				for (int r = 0; r < FIELD_ROWS; r++)
					if (RW'(r) <= full_row)
						board[r] <= shifted[r];  // rows above drop by one
				clear <= 1'b1;
				score <= score + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* common/tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

	localparam int FIELD_COLS = 24;
	localparam int FIELD_ROWS = 24;
	localparam int CELL_PX = 20;
	localparam int LINE_PX = 640;
	localparam int STRIPE_LO = 480;
	localparam int STRIPE_HI = 500;
	localparam int SPAWN_X = 280;
	localparam int NUM_SHAPES = 15;

	typedef logic [$clog2(NUM_SHAPES)-1:0] shape_t;

	// wide enough for any reference point plus offsets
	typedef logic signed [6:0] col_t;
	typedef logic signed [6:0] row_t;
	typedef logic signed [2:0] ofs_t;

	typedef logic [18:0] pixel_addr_t;
	typedef logic [9:0] coord_t;

	// cell offsets from the reference cell, cell 0 always at the reference
	localparam ofs_t SHAPE_DX [16][4] = '{
		'{0, 1, 0, 1},   // square
		'{0, 1, 2, 3},   // long bar, flat
		'{0, 0, 0, 0},   // long bar, upright
		'{0, -1, 0, 1},  // t, point up
		'{0, 0, 1, 0},
		'{0, 1, 2, 1},
		'{0, -1, 0, 0},
		'{0, 0, 0, 1},   // l family
		'{0, 1, 2, 0},
		'{0, 1, 1, 1},
		'{0, -2, -1, 0},
		'{0, 0, 1, 1},   // s pair
		'{0, 1, -1, 0},
		'{0, -1, 0, -1}, // z pair
		'{0, 1, 1, 2},
		'{0, 1, 0, 1}    // code 15 never used
	};

	localparam ofs_t SHAPE_DY [16][4] = '{
		'{0, 0, 1, 1},
		'{0, 0, 0, 0},
		'{0, 1, 2, 3},
		'{0, 1, 1, 1},
		'{0, 1, 1, 2},
		'{0, 0, 0, 1},
		'{0, 1, 1, 2},
		'{0, 1, 2, 2},
		'{0, 0, 0, 1},
		'{0, 0, 1, 2},
		'{0, 1, 1, 1},
		'{0, 1, 1, 2},
		'{0, 0, 1, 1},
		'{0, 1, 1, 2},
		'{0, 0, 1, 1},
		'{0, 0, 1, 1}
	};

	// spawn order
	localparam shape_t NEXT_SHAPE [16] = '{
		1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 0, 0
	};

	// rotation steps within each family
	localparam shape_t ROT_SHAPE [16] = '{
		0, 2, 1, 4, 5, 6, 3, 8, 9, 10, 7, 12, 11, 14, 13, 0
	};

endpackage

`default_nettype wire

/* hdl/piece_footprint.sv */
`default_nettype none

module piece_footprint import tetris_pkg::*; #(
	parameter int CELL_PX = tetris_pkg::CELL_PX
) (
	input logic ADDR,
	input logic rst_n,
	input coord_t ref_x,
	input coord_t ref_y,
	input shape_t shape,
	output col_t cell_col [4],
	output row_t cell_row [4]
);

	// parked inside the top row so an empty board sees no contact
	localparam int PARK_COL = 1;

	int base_col;
	int base_row;

	always_comb begin
		base_col = int'(ref_x) / CELL_PX;
		base_row = int'(ref_y) / CELL_PX;
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				cell_col[i] <= col_t'(PARK_COL);
				cell_row[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				cell_col[i] <= col_t'(base_col + int'(SHAPE_DX[shape][i]));
				cell_row[i] <= row_t'(base_row + int'(SHAPE_DY[shape][i]));
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/pixel_select.sv */
`default_nettype none

module pixel_select import tetris_pkg::*; #(
	parameter int CELL_PX = tetris_pkg::CELL_PX,
	parameter int LINE_PX = tetris_pkg::LINE_PX,
	parameter int STRIPE_LO = tetris_pkg::STRIPE_LO,
	parameter int STRIPE_HI = tetris_pkg::STRIPE_HI,
	parameter int FIELD_COLS = tetris_pkg::FIELD_COLS,
	parameter int FIELD_ROWS = tetris_pkg::FIELD_ROWS
) (
	input logic ADDR,
	input logic rst_n,
	input pixel_addr_t pixel_addr,
	input logic [FIELD_COLS*FIELD_ROWS-1:0] occupied,
	input col_t cell_col [4],
	input row_t cell_row [4],
	output logic sel
);

	localparam int OW = $clog2(FIELD_COLS * FIELD_ROWS);

	logic on_board;
	logic on_piece;
	logic on_stripe;

	always_comb begin
		int x;
		int y;
		int pc;
		int pr;
		x = int'(pixel_addr % LINE_PX);
		y = int'(pixel_addr / LINE_PX);
		pc = x / CELL_PX;
		pr = y / CELL_PX;
		on_board = 1'b0;
		if (pc < FIELD_COLS && pr < FIELD_ROWS)
			on_board = occupied[OW'(pr * FIELD_COLS + pc)];
		on_piece = 1'b0;
		for (int i = 0; i < 4; i++)
			if (int'(cell_col[i]) == pc && int'(cell_row[i]) == pr)
				on_piece = 1'b1;
		on_stripe = (x > STRIPE_LO) && (x < STRIPE_HI);  // divider
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n)
			sel <= 1'b0;
		else
			sel <= on_board || on_piece || on_stripe;
	end

endmodule

`default_nettype wire

/* hdl/shape_sequencer.sv */
`default_nettype none

module shape_sequencer import tetris_pkg::*; #(
	parameter int SPAWN_X = tetris_pkg::SPAWN_X
) (
	input logic ADDR,
	input logic rst_n,
	input coord_t ref_x,
	input coord_t ref_y,
	input logic change_shape,
	output shape_t shape
);

	logic at_spawn;

	assign at_spawn = (int'(ref_x) == SPAWN_X) && (ref_y == '0);

	always_ff @(posedge ADDR) begin
		if (!rst_n)
			shape <= '0;
		else if (at_spawn)
			shape <= NEXT_SHAPE[shape];  // new piece
		else if (change_shape)
			shape <= ROT_SHAPE[shape];  // level, steps every cycle held
	end

endmodule

`default_nettype wire

/* hdl/tetris_core.sv */
`default_nettype none

module tetris_core import tetris_pkg::*; (
	input logic ADDR,
	input logic rst_n,
	input coord_t ref_x,
	input coord_t ref_y,
	input pixel_addr_t pixel_addr,
	input logic change_shape,
	input logic start_over,
	output logic sel,
	output logic stop,
	output logic hit,
	output logic clear,
	output shape_t shape,
	output logic [15:0] score
);

	col_t cell_col [4];
	row_t cell_row [4];
	logic [FIELD_COLS*FIELD_ROWS-1:0] occupied;

	shape_sequencer #(
		.SPAWN_X(SPAWN_X)
	) shape_sequencer_inst (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.ref_x(ref_x),
		.ref_y(ref_y),
		.change_shape(change_shape),
		.shape(shape)
	);

	piece_footprint #(
		.CELL_PX(CELL_PX)
	) piece_footprint_inst (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.ref_x(ref_x),
		.ref_y(ref_y),
		.shape(shape),
		.cell_col(cell_col),
		.cell_row(cell_row)
	);

	board_store #(
		.FIELD_COLS(FIELD_COLS),
		.FIELD_ROWS(FIELD_ROWS)
	) board_store_inst (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.start_over(start_over),
		.cell_col(cell_col),
		.cell_row(cell_row),
		.occupied(occupied),
		.stop(stop),
		.hit(hit),
		.clear(clear),
		.score(score)
	);

	// display side sees the board as it stands before each edge
	pixel_select #(
		.CELL_PX(CELL_PX),
		.LINE_PX(LINE_PX),
		.STRIPE_LO(STRIPE_LO),
		.STRIPE_HI(STRIPE_HI),
		.FIELD_COLS(FIELD_COLS),
		.FIELD_ROWS(FIELD_ROWS)
	) pixel_select_inst (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.pixel_addr(pixel_addr),
		.occupied(occupied),
		.cell_col(cell_col),
		.cell_row(cell_row),
		.sel(sel)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator, exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_tetris -o tb_tetris
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_tetris
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

/* sources.f */
common/tetris_pkg.sv
hdl/piece_footprint.sv
hdl/shape_sequencer.sv
board/board_store.sv
hdl/pixel_select.sv
hdl/tetris_core.sv
test/tetris_assert.sv
test/tb_tetris.sv

/* test/tb_tetris.sv */
`default_nettype none

module tb_tetris import tetris_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int SCAN_CYCLES = FIELD_ROWS * CELL_PX * STRIPE_HI;
	localparam int TOTAL_CYCLES = 10 + 200 + 600 + 3 * SCAN_CYCLES + 1000;

	logic ADDR;
	logic rst_n;
	coord_t ref_x;
	coord_t ref_y;
	pixel_addr_t pixel_addr;
	logic change_shape;
	logic start_over;
	logic sel;
	logic stop;
	logic hit;
	logic clear;
	shape_t shape;
	logic [15:0] score;

	// model state, as it stands after the last edge
	int m_shape;
	int m_col [4];
	int m_row [4];
	bit [FIELD_COLS-1:0] m_board [FIELD_ROWS];
	logic [15:0] m_score;
	bit m_stop;
	bit m_hit;
	bit m_clear;
	bit m_sel;
	int n_clear;

	tetris_core tetris_core_inst (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.ref_x(ref_x),
		.ref_y(ref_y),
		.pixel_addr(pixel_addr),
		.change_shape(change_shape),
		.start_over(start_over),
		.sel(sel),
		.stop(stop),
		.hit(hit),
		.clear(clear),
		.shape(shape),
		.score(score)
	);

	always #(CLK_PERIOD / 2) ADDR = ~ADDR;

	function automatic int next_rule(input int s);
		return (s == NUM_SHAPES - 1) ? 0 : s + 1;
	endfunction

	function automatic int rot_rule(input int s);
		case (s)
			0: return 0;
			1: return 2;
			2: return 1;
			6: return 3;
			10: return 7;
			11: return 12;
			12: return 11;
			13: return 14;
			14: return 13;
			default: return s + 1;  // inside the two four-step cycles
		endcase
	endfunction

	function automatic bit in_field(input int c, input int r);
		return c >= 0 && c < FIELD_COLS && r >= 0 && r < FIELD_ROWS;
	endfunction

	function automatic bit occ(input int c, input int r);
		return in_field(c, r) && m_board[r][c];
	endfunction

	function automatic bit is_cell(input int c, input int r);
		bit found;
		found = 1'b0;
		for (int i = 0; i < 4; i++)
			if (m_col[i] == c && m_row[i] == r)
				found = 1'b1;
		return found;
	endfunction

	function automatic bit probe_hits(input int c, input int r);
		return occ(c, r) && !is_cell(c, r);
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s got 0x%h expected 0x%h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// one rising edge of the model, all from pre-edge state
	task automatic model_edge();
		int nc [4];
		int nr [4];
		int x;
		int y;
		int full;
		bit land;
		bit touch;
		bit nsel;
		x = int'(pixel_addr) % LINE_PX;
		y = int'(pixel_addr) / LINE_PX;
		nsel = (x > STRIPE_LO && x < STRIPE_HI) || is_cell(x / CELL_PX, y / CELL_PX)
			|| occ(x / CELL_PX, y / CELL_PX);
		land = 1'b0;
		touch = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (m_row[i] + 1 >= FIELD_ROWS || probe_hits(m_col[i], m_row[i] + 1))
				land = 1'b1;
			if (m_col[i] < 1 || m_col[i] + 1 >= FIELD_COLS)
				touch = 1'b1;
			else if (probe_hits(m_col[i] - 1, m_row[i]) || probe_hits(m_col[i] + 1, m_row[i]))
				touch = 1'b1;
			nc[i] = int'(ref_x) / CELL_PX + int'(SHAPE_DX[m_shape][i]);
			nr[i] = int'(ref_y) / CELL_PX + int'(SHAPE_DY[m_shape][i]);
		end
		m_clear = 1'b0;
		if (start_over) begin
			for (int r = 0; r < FIELD_ROWS; r++)
				m_board[r] = '0;
			m_score = '0;
		end else if (land) begin
			for (int i = 0; i < 4; i++)
				if (in_field(m_col[i], m_row[i]))
					m_board[m_row[i]][m_col[i]] = 1'b1;
		end else begin
			full = -1;
			for (int r = 0; r < FIELD_ROWS; r++)
				if (&m_board[r])
					full = r;  // keeps the lowest
			if (full >= 0) begin
				for (int r = full; r > 0; r--)
					m_board[r] = m_board[r - 1];
				m_board[0] = '0;
				m_clear = 1'b1;
				m_score = m_score + 16'd1;
			end
		end
		if (int'(ref_x) == SPAWN_X && ref_y == '0)
			m_shape = next_rule(m_shape);
		else if (change_shape)
			m_shape = rot_rule(m_shape);
		m_col = nc;
		m_row = nr;
		m_stop = land;
		m_hit = touch;
		m_sel = nsel;
	endtask

	task automatic step();
		model_edge();
		@(posedge ADDR);
		#1;
		compare("shape", 32'(shape), 32'(m_shape));
		compare("stop", 32'(stop), 32'(m_stop));
		compare("hit", 32'(hit), 32'(m_hit));
		compare("clear", 32'(clear), 32'(m_clear));
		compare("score", 32'(score), 32'(m_score));
		compare("sel", 32'(sel), 32'(m_sel));
	endtask

	task automatic place(input int x, input int y, input int cycles);
		ref_x = coord_t'(x);
		ref_y = coord_t'(y);
		repeat (cycles) step();
	endtask

	task automatic scan_pixels();
		for (int y = 0; y < FIELD_ROWS * CELL_PX; y++)
			for (int x = 0; x < STRIPE_HI; x++) begin
				pixel_addr = pixel_addr_t'(y * LINE_PX + x);
				step();
			end
	endtask

	initial begin
		#(TOTAL_CYCLES * 2 * CLK_PERIOD);
		$display("timeout, run went past %0d cycles", 2 * TOTAL_CYCLES);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(96));
		ADDR = 1'b0;
		rst_n = 1'b0;
		ref_x = '0;
		ref_y = '0;
		pixel_addr = '0;
		change_shape = 1'b0;
		start_over = 1'b0;
		m_shape = 0;
		m_col = '{1, 1, 1, 1};  // piece parked at column 1 of the top row in reset
		m_row = '{0, 0, 0, 0};
		for (int r = 0; r < FIELD_ROWS; r++)
			m_board[r] = '0;
		m_score = '0;
		m_stop = 1'b0;
		m_hit = 1'b0;
		m_clear = 1'b0;
		m_sel = 1'b0;
		repeat (10) @(posedge ADDR);
		#1;
		rst_n = 1'b1;
		compare("reset_outputs", 32'({sel, stop, hit, clear, shape, score}), 32'd0);
		repeat (3) step();

		// shape walk with spawn and rotate mixed
		repeat (200) begin
			ref_x = coord_t'(($urandom_range(0, 3) == 0) ? SPAWN_X : $urandom_range(0, 639));
			ref_y = coord_t'(($urandom_range(0, 1) == 0) ? 0 : $urandom_range(0, 479));
			change_shape = 1'($urandom_range(0, 1));
			step();
		end

		// random drops build up a random board
		repeat (150) begin
			change_shape = ($urandom_range(0, 7) == 0);
			place($urandom_range(0, 499), $urandom_range(0, 479), $urandom_range(2, 4));
		end
		change_shape = 1'b0;

		place(200, 100, 2);
		scan_pixels();

		// two full rows of flat bars and a stub on top
		place(0, 0, 3);
		start_over = 1'b1;
		step();
		start_over = 1'b0;
		ref_x = coord_t'(SPAWN_X);
		while (m_shape != 1)
			step();
		place(0, 0, 2);
		for (int r = FIELD_ROWS - 1; r >= FIELD_ROWS - 2; r--) begin
			for (int c = 0; c < FIELD_COLS; c += 4)
				place(c * CELL_PX, r * CELL_PX, 3);
		end
		place(0, (FIELD_ROWS - 3) * CELL_PX, 3);
		ref_x = '0;
		ref_y = '0;
		n_clear = 0;
		repeat (8) begin
			step();
			if (clear)
				n_clear++;
		end
		compare("clear_count", 32'(n_clear), 32'd2);
		compare("score", 32'(score), 32'd2);
		scan_pixels();

		start_over = 1'b1;
		step();
		start_over = 1'b0;
		step();
		compare("score", 32'(score), 32'd0);
		scan_pixels();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/tetris_assert.sv */
`default_nettype none

module tetris_assert (
	input logic ADDR,
	input logic rst_n,
	input logic start_over,
	input logic stop,
	input logic hit,
	input logic clear,
	input logic [15:0] score
);

	// removal only in cycles without a landing
	no_clear_on_stop: assert property (@(posedge ADDR) disable iff (!rst_n) !(clear && stop))
		else $error("clear and stop high in the same cycle");

	score_step: assert property (@(posedge ADDR) disable iff (!rst_n)
		$past(rst_n) && !$past(start_over) |-> score == $past(score) + {15'd0, clear})
		else $error("score did not step with clear");

	reset_state: assert property (@(posedge ADDR)
		$rose(rst_n) |-> !stop && !hit && !clear && score == 16'd0)
		else $error("outputs not cleared by reset");

endmodule

bind board_store tetris_assert tetris_assert_inst (
	.ADDR(ADDR),
	.rst_n(rst_n),
	.start_over(start_over),
	.stop(stop),
	.hit(hit),
	.clear(clear),
	.score(score)
);

`default_nettype wire
